// File: Makefile
# Verilator lint and simulation of the cpu16 back end

TOP       ?= cpu16_backend_tb
LOG       ?= sim.log
FLAGS     ?=
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FILELIST  := sim.f
SOURCES   := $(wildcard hw/*.sv hw/*.svh testbench/*.sv)

VFLAGS := --timing --assert -f $(FILELIST) --top-module $(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(FLAGS)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR) $(FLAGS)

sim: $(OBJ_DIR)/V$(TOP)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/cpu16_backend.sv
/*
 * cpu16 back end top: execute, memory, writeback and register file
 * one instruction may issue per cycle, there is no stall input
 */

`timescale 1ns/1ps
`include "cpu16_macros.svh"

module cpu16_backend (
	input  logic                        CLK,
	input  logic                        rst_n,
	input  logic                        issue_valid,
	input  logic [`CPU16_BITS-1:0]      instruction,
	input  logic [`CPU16_ADDR_BITS-1:0] pc,
	input  logic [`CPU16_BITS-1:0]      port_in,
	output logic [`CPU16_BITS-1:0]      port_out,
	output logic                        port_wr,
	output logic                        wb_valid,
	output logic                        wb_we,
	output logic [`CPU16_REG_BITS-1:0]  wb_sel,
	output logic [`CPU16_BITS-1:0]      wb_data
);

	// ~~~~~~~~~~~~~~~~~~~~
	// register file read ports
	logic [`CPU16_REG_BITS-1:0]  rd_sel_a, rd_sel_b;
	logic [`CPU16_BITS-1:0]      rd_data_a, rd_data_b;

	// stage 3
	logic                        s3_valid;
	logic [`CPU16_BITS-1:0]      s3_instruction, s3_alu, s3_store_data;
	logic [`CPU16_ADDR_BITS-1:0] s3_pc, s3_addr;

	// stage 4
	logic                        s4_valid;
	logic [`CPU16_BITS-1:0]      s4_instruction, s4_alu, s4_mem, s4_port;
	logic [`CPU16_ADDR_BITS-1:0] s4_pc;

	cpu16_execute u_execute (
		.CLK, .rst_n, .issue_valid, .instruction, .pc,
		.rd_sel_a, .rd_sel_b, .rd_data_a, .rd_data_b,
		.s3_valid, .s3_instruction, .s3_pc, .s3_alu, .s3_store_data, .s3_addr
	);

	cpu16_memory u_memory (
		.CLK, .rst_n,
		.s3_valid, .s3_instruction, .s3_pc, .s3_alu, .s3_store_data, .s3_addr,
		.port_in, .port_out, .port_wr,
		.s4_valid, .s4_instruction, .s4_pc, .s4_alu, .s4_mem, .s4_port
	);

	cpu16_writeback u_writeback (
		.s4_valid, .s4_instruction, .s4_pc, .s4_alu, .s4_mem, .s4_port,
		.wb_we, .wb_sel, .wb_data
	);

	// the retire port drives the write port directly
	cpu16_regfile u_regfile (
		.CLK, .rst_n, .rd_sel_a, .rd_sel_b, .rd_data_a, .rd_data_b,
		.wr_en(wb_we), .wr_sel(wb_sel), .wr_data(wb_data)
	);

	assign wb_valid = s4_valid;	// every issued instruction retires two edges later

endmodule

// File: hw/cpu16_execute.sv
/*
 * stage 3 of the back end: operand read, ALU and load/store address
 * there are no hazard checks, so a reader must issue three cycles after its writer
 */

`timescale 1ns/1ps
`include "cpu16_macros.svh"

module cpu16_execute
	import cpu16_pkg::*;
(
	input  logic                        CLK,
	input  logic                        rst_n,
	input  logic                        issue_valid,
	input  logic [`CPU16_BITS-1:0]      instruction,
	input  logic [`CPU16_ADDR_BITS-1:0] pc,
	output logic [`CPU16_REG_BITS-1:0]  rd_sel_a,
	output logic [`CPU16_REG_BITS-1:0]  rd_sel_b,
	input  logic [`CPU16_BITS-1:0]      rd_data_a,
	input  logic [`CPU16_BITS-1:0]      rd_data_b,
	output logic                        s3_valid,
	output logic [`CPU16_BITS-1:0]      s3_instruction,
	output logic [`CPU16_ADDR_BITS-1:0] s3_pc,
	output logic [`CPU16_BITS-1:0]      s3_alu,
	output logic [`CPU16_BITS-1:0]      s3_store_data,
	output logic [`CPU16_ADDR_BITS-1:0] s3_addr
);

	alu_op_t                     op;
	logic [`CPU16_BITS-1:0]      operand_b;
	logic [`CPU16_BITS-1:0]      alu_result;
	logic [`CPU16_ADDR_BITS-1:0] mem_addr;

	assign rd_sel_a = reg_dest_from_ins(instruction);	// rd, store data and poke value
	assign rd_sel_b = reg_src_from_ins(instruction);	// rs or the load/store base

	// reg-imm always adds because its immediate overlaps the op field
	always_comb begin
		op = alu_op_t'(instruction[3:0]);
		operand_b = rd_data_b;
		if (class_from_ins(instruction) == CLASS_ALU_RI) begin
			op = ALU_ADD;
			operand_b = imm8_from_ins(instruction);
		end
	end

	always_comb begin
		case (op)
			ALU_ADD: alu_result = rd_data_a + operand_b;
			ALU_SUB: alu_result = rd_data_a - operand_b;
			ALU_AND: alu_result = rd_data_a & operand_b;
			ALU_OR:  alu_result = rd_data_a | operand_b;
			ALU_XOR: alu_result = rd_data_a ^ operand_b;
			ALU_SHL: alu_result = rd_data_a << 1;
			ALU_SHR: alu_result = rd_data_a >> 1;
			ALU_INC: alu_result = rd_data_a + `CPU16_BITS'(1);
			ALU_DEC: alu_result = rd_data_a - `CPU16_BITS'(1);
			ALU_NOT: alu_result = ~rd_data_a;
			default: alu_result = rd_data_a;	// unused op codes pass the operand through
		endcase
	end

	assign mem_addr = rd_data_b + {{(`CPU16_ADDR_BITS-3){1'b0}}, offset_from_ins(instruction)};

	// ~~~~~~~~~~~~~~~~~~~~
	// stage 3 registers
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			s3_valid <= 1'b0;
			s3_instruction <= '0;
		end else begin
			s3_valid <= issue_valid;
			s3_instruction <= instruction;
		end
	end

	always_ff @(posedge CLK) begin
		s3_pc <= pc;
		s3_alu <= alu_result;
		s3_store_data <= rd_data_a;
		s3_addr <= mem_addr;
	end

endmodule

// File: hw/cpu16_macros.svh
/*
 * widths, register numbers and RAM depth for the cpu16 back end
 * the RAM is addressed by the low CPU16_RAM_ADDR_BITS of the address
 */

`ifndef CPU16_MACROS_SVH
`define CPU16_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// datapath widths
`define CPU16_BITS		16	// data and instruction word
`define CPU16_REG_BITS		4	// register index
`define CPU16_ADDR_BITS		16	// program counter and data address

// ~~~~~~~~~~~~~~~~~~~~
// register file
`define CPU16_NUM_REGS		16
`define CPU16_LINK_REG		15	// written by branch with link
`define CPU16_INT_LINK_REG	14	// written on interrupt

// data RAM, 256 words
`define CPU16_RAM_WORDS		256
`define CPU16_RAM_ADDR_BITS	8

`endif

// File: hw/cpu16_memory.sv
/*
 * stage 4 of the back end: data RAM, IO port and the stage 4 registers
 * the RAM has no reset and reads back undefined until written
 */

`timescale 1ns/1ps
`include "cpu16_macros.svh"

module cpu16_memory
	import cpu16_pkg::*;
(
	input  logic                        CLK,
	input  logic                        rst_n,
	input  logic                        s3_valid,
	input  logic [`CPU16_BITS-1:0]      s3_instruction,
	input  logic [`CPU16_ADDR_BITS-1:0] s3_pc,
	input  logic [`CPU16_BITS-1:0]      s3_alu,
	input  logic [`CPU16_BITS-1:0]      s3_store_data,
	input  logic [`CPU16_ADDR_BITS-1:0] s3_addr,
	input  logic [`CPU16_BITS-1:0]      port_in,
	output logic [`CPU16_BITS-1:0]      port_out,
	output logic                        port_wr,
	output logic                        s4_valid,
	output logic [`CPU16_BITS-1:0]      s4_instruction,
	output logic [`CPU16_ADDR_BITS-1:0] s4_pc,
	output logic [`CPU16_BITS-1:0]      s4_alu,
	output logic [`CPU16_BITS-1:0]      s4_mem,
	output logic [`CPU16_BITS-1:0]      s4_port
);

	logic [`CPU16_BITS-1:0]          ram [0:`CPU16_RAM_WORDS-1];
	logic [`CPU16_RAM_ADDR_BITS-1:0] ram_addr;
	logic                            is_ls, is_io, ram_we, peek, poke;

	assign ram_addr = s3_addr[`CPU16_RAM_ADDR_BITS-1:0];	// upper address bits ignored
	assign is_ls = s3_valid && class_from_ins(s3_instruction) == CLASS_LOAD_STORE;
	assign is_io = s3_valid && class_from_ins(s3_instruction) == CLASS_PEEK_POKE;
	assign ram_we = is_ls && is_store_or_poke_from_ins(s3_instruction);
	assign poke = is_io && is_store_or_poke_from_ins(s3_instruction);
	assign peek = is_io && !is_store_or_poke_from_ins(s3_instruction);

	// read is synchronous and returns the old word on a store to the same address
	always_ff @(posedge CLK) begin
		if (ram_we)
			ram[ram_addr] <= s3_store_data;
		if (s3_valid)
			s4_mem <= ram[ram_addr];
	end

	always_ff @(posedge CLK) begin
		s4_pc <= s3_pc;
		s4_alu <= s3_alu;
		if (peek)
			s4_port <= port_in;	// port_in sampled once, at the end of stage 3
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// control and IO registers
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			s4_valid <= 1'b0;
			s4_instruction <= '0;
			port_out <= '0;
			port_wr <= 1'b0;
		end else begin
			s4_valid <= s3_valid;
			s4_instruction <= s3_instruction;
			port_wr <= poke;	// one cycle pulse per poke
			if (poke)
				port_out <= s3_store_data;	// holds until the next poke
		end
	end

endmodule

// File: hw/cpu16_pkg.sv
/*
 * instruction classes, ALU ops and field decode shared by all stages
 * class codes not listed in ins_class_t behave as nop
 */

`include "cpu16_macros.svh"

package cpu16_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// instruction class, bits 15..12
	typedef enum logic [3:0] {
		CLASS_NOP        = 4'd0,
		CLASS_ALU_RR     = 4'd1,
		CLASS_ALU_RI     = 4'd2,
		CLASS_ALU_SINGLE = 4'd3,
		CLASS_BRANCH     = 4'd4,
		CLASS_LOAD_STORE = 4'd5,
		CLASS_PEEK_POKE  = 4'd7,
		CLASS_INT        = 4'd8
	} ins_class_t;

	// ALU op, bits 3..0
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SHL = 4'd5,	// shift left by one
		ALU_SHR = 4'd6,	// shift right by one
		ALU_INC = 4'd7,
		ALU_DEC = 4'd8,
		ALU_NOT = 4'd9
	} alu_op_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// field decode
	function automatic ins_class_t class_from_ins(input logic [`CPU16_BITS-1:0] ins);
		return ins_class_t'(ins[15:12]);
	endfunction

	function automatic logic [`CPU16_REG_BITS-1:0] reg_dest_from_ins(
		input logic [`CPU16_BITS-1:0] ins);
		return ins[11:8];
	endfunction

	function automatic logic [`CPU16_REG_BITS-1:0] reg_src_from_ins(
		input logic [`CPU16_BITS-1:0] ins);
		return ins[7:4];
	endfunction

	// zero extended to the data width
	function automatic logic [`CPU16_BITS-1:0] imm8_from_ins(input logic [`CPU16_BITS-1:0] ins);
		return {{(`CPU16_BITS-8){1'b0}}, ins[7:0]};
	endfunction

	function automatic logic [2:0] offset_from_ins(input logic [`CPU16_BITS-1:0] ins);
		return ins[2:0];
	endfunction

	function automatic logic is_store_or_poke_from_ins(input logic [`CPU16_BITS-1:0] ins);
		return ins[3];
	endfunction

	function automatic logic is_link_from_ins(input logic [`CPU16_BITS-1:0] ins);
		return ins[11];	// shares a bit with the dest field, only meaningful for branches
	endfunction

endpackage

// File: hw/cpu16_regfile.sv
/*
 * sixteen registers, two combinational read ports, one write port
 * r0 reads as zero, writes to it are accepted and dropped
 */

`timescale 1ns/1ps
`include "cpu16_macros.svh"

module cpu16_regfile (
	input  logic                       CLK,
	input  logic                       rst_n,
	input  logic [`CPU16_REG_BITS-1:0] rd_sel_a,
	input  logic [`CPU16_REG_BITS-1:0] rd_sel_b,
	output logic [`CPU16_BITS-1:0]     rd_data_a,
	output logic [`CPU16_BITS-1:0]     rd_data_b,
	input  logic                       wr_en,
	input  logic [`CPU16_REG_BITS-1:0] wr_sel,
	input  logic [`CPU16_BITS-1:0]     wr_data
);

	logic [`CPU16_BITS-1:0] regs [0:`CPU16_NUM_REGS-1];

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU16_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_sel != '0) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// no bypass from the write port, the issuer spaces dependent instructions
	assign rd_data_a = (rd_sel_a == '0) ? '0 : regs[rd_sel_a];
	assign rd_data_b = (rd_sel_b == '0) ? '0 : regs[rd_sel_b];

endmodule

// File: hw/cpu16_writeback.sv
/*
 * writeback select: destination register and value for the stage 4 instruction
 * purely combinational, the register file writes at the next edge
 */

`timescale 1ns/1ps
`include "cpu16_macros.svh"

module cpu16_writeback
	import cpu16_pkg::*;
(
	input  logic                        s4_valid,
	input  logic [`CPU16_BITS-1:0]      s4_instruction,
	input  logic [`CPU16_ADDR_BITS-1:0] s4_pc,
	input  logic [`CPU16_BITS-1:0]      s4_alu,
	input  logic [`CPU16_BITS-1:0]      s4_mem,
	input  logic [`CPU16_BITS-1:0]      s4_port,
	output logic                        wb_we,
	output logic [`CPU16_REG_BITS-1:0]  wb_sel,
	output logic [`CPU16_BITS-1:0]      wb_data
);

	logic wr_req;	// the instruction class asks for a register write

	always_comb begin
		wr_req = 1'b0;
		wb_sel = '0;
		wb_data = '0;

		case (class_from_ins(s4_instruction))
			// single-reg ops use the dest field as operand, so they write back to it too
			CLASS_ALU_RR, CLASS_ALU_RI, CLASS_ALU_SINGLE: begin
				wr_req = 1'b1;
				wb_sel = reg_dest_from_ins(s4_instruction);
				wb_data = s4_alu;
			end
			CLASS_BRANCH: begin
				if (is_link_from_ins(s4_instruction)) begin
					wr_req = 1'b1;
					wb_sel = `CPU16_REG_BITS'(`CPU16_LINK_REG);
					wb_data = s4_pc;
				end
			end
			CLASS_LOAD_STORE: begin
				if (!is_store_or_poke_from_ins(s4_instruction)) begin	// load
					wr_req = 1'b1;
					wb_sel = reg_dest_from_ins(s4_instruction);
					wb_data = s4_mem;
				end
			end
			CLASS_PEEK_POKE: begin
				if (!is_store_or_poke_from_ins(s4_instruction)) begin	// peek
					wr_req = 1'b1;
					wb_sel = reg_dest_from_ins(s4_instruction);
					wb_data = s4_port;
				end
			end
			CLASS_INT: begin
				wr_req = 1'b1;
				wb_sel = `CPU16_REG_BITS'(`CPU16_INT_LINK_REG);
				wb_data = s4_pc;
			end
			default: ;
		endcase
	end

	assign wb_we = s4_valid && wr_req;

endmodule

// File: sim.f
+incdir+hw
hw/cpu16_pkg.sv
hw/cpu16_regfile.sv
hw/cpu16_execute.sv
hw/cpu16_memory.sv
hw/cpu16_writeback.sv
hw/cpu16_backend.sv
testbench/cpu16_backend_props.sv
testbench/cpu16_backend_tb.sv

// File: testbench/cpu16_backend_props.sv
/*
 * concurrent checks on the retire and IO outputs of the back end
 * bound into every cpu16_backend instance
 */

`timescale 1ns/1ps

module cpu16_backend_props (
	input logic CLK,
	input logic rst_n,
	input logic port_wr,
	input logic wb_valid,
	input logic wb_we
);

	// each poke gives a single cycle pulse
	port_wr_pulse: assert property (@(posedge CLK) disable iff (!rst_n) port_wr |=> !port_wr)
		else $error("port_wr high for two consecutive cycles");

	we_needs_valid: assert property (@(posedge CLK) disable iff (!rst_n) wb_we |-> wb_valid)
		else $error("wb_we high without wb_valid");

	quiet_in_reset: assert property (@(posedge CLK) !rst_n |-> (!wb_valid && !port_wr))
		else $error("wb_valid or port_wr high during reset");	// async reset clears both

endmodule

bind cpu16_backend cpu16_backend_props u_props (.*);

// File: testbench/cpu16_backend_tb.sv
/*
 * directed tests for the cpu16 back end, one instruction in flight at a time
 * expected values come from a register model built from the encoding rules
 */

`timescale 1ns/1ps
`include "cpu16_macros.svh"

module cpu16_backend_tb;

	logic                        CLK;
	logic                        rst_n;
	logic                        issue_valid;
	logic [`CPU16_BITS-1:0]      instruction;
	logic [`CPU16_ADDR_BITS-1:0] pc;
	logic [`CPU16_BITS-1:0]      port_in;
	logic [`CPU16_BITS-1:0]      port_out;
	logic                        port_wr;
	logic                        wb_valid;
	logic                        wb_we;
	logic [`CPU16_REG_BITS-1:0]  wb_sel;
	logic [`CPU16_BITS-1:0]      wb_data;

	logic [`CPU16_BITS-1:0] model_regs [0:`CPU16_NUM_REGS-1];	// r0 is never written
	logic [15:0]            lfsr;
	int                     errors;
	int                     checks;

	cpu16_backend uut (.*);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	// ~~~~~~~~~~~~~~~~~~~~
	// stimulus and checking helpers

	// galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			value = {value[14:0], lfsr[0]};
		end
		return value;
	endfunction

	// result of an ALU class instruction computed from the model registers
	function automatic logic [15:0] alu_expect(input logic [15:0] ins);
		logic [15:0] a;
		logic [15:0] b;
		logic [3:0]  op;
		a = model_regs[ins[11:8]];
		b = model_regs[ins[7:4]];
		op = ins[3:0];
		if (ins[15:12] == 4'd2) begin
			b = {8'b0, ins[7:0]};	// reg-imm always adds
			op = 4'd0;
		end
		case (op)
			4'd0: return a + b;
			4'd1: return a - b;
			4'd2: return a & b;
			4'd3: return a | b;
			4'd4: return a ^ b;
			4'd5: return {a[14:0], 1'b0};
			4'd6: return {1'b0, a[15:1]};
			4'd7: return a + 16'd1;
			4'd8: return a - 16'd1;
			4'd9: return ~a;
			default: return a;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("mismatch in %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("mismatch in %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic issue(input logic [15:0] ins, input logic [15:0] pcv);
		@(posedge CLK);
		#2;
		issue_valid = 1'b1;
		instruction = ins;
		pc = pcv;
		@(posedge CLK);
		#2;
		issue_valid = 1'b0;
		instruction = '0;
	endtask

	// returns at the falling edge where the instruction retires
	task automatic wait_retire(input string name, output logic seen);
		int n;
		n = 0;
		@(negedge CLK);
		while (!wb_valid && n < 8) begin
			@(negedge CLK);
			n++;
		end
		seen = wb_valid;
		if (!seen) begin
			errors++;
			$display("timeout in %s: no instruction retired within 8 cycles", name);
		end
	endtask

	task automatic run_ins(input string name, input logic [15:0] ins, input logic [15:0] pcv,
		input logic exp_we, input logic [3:0] exp_sel, input logic [15:0] exp_data);
		logic seen;
		issue(ins, pcv);
		wait_retire(name, seen);
		if (seen) begin
			check_bit(name, exp_we, wb_we);
			if (exp_we) begin
				check_value(name, {12'b0, exp_sel}, {12'b0, wb_sel});
				check_value(name, exp_data, wb_data);
			end
		end
		if (exp_we && exp_sel != 4'd0)
			model_regs[exp_sel] = exp_data;	// written at the edge after retire
	endtask

	task automatic alu(input string name, input logic [15:0] ins);
		run_ins(name, ins, 16'h0, 1'b1, ins[11:8], alu_expect(ins));
	endtask

	// clear, add the high byte, shift it up by eight, add the low byte
	task automatic load_reg(input logic [3:0] r, input logic [15:0] value);
		alu("load clear", {4'd1, r, r, 4'd4});
		alu("load high", {4'd2, r, value[15:8]});
		for (int i = 0; i < 8; i++)
			alu("load shift", {4'd3, r, 4'd0, 4'd5});
		alu("load low", {4'd2, r, value[7:0]});
	endtask

	// a poke retires without a write and pulses port_wr for one cycle
	task automatic poke_check(input string name, input logic [3:0] r);
		logic seen;
		issue({4'd7, r, 4'd0, 4'd8}, 16'h0);
		wait_retire(name, seen);
		if (seen) begin
			check_bit(name, 1'b0, wb_we);
			check_bit(name, 1'b1, port_wr);
			check_value(name, model_regs[r], port_out);
			@(negedge CLK);
			check_bit(name, 1'b0, port_wr);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// tests

	task automatic reset_state();
		for (int i = 0; i < 4; i++) begin
			@(negedge CLK);
			check_bit("reset idle", 1'b0, wb_valid);
		end
		for (int r = 0; r < `CPU16_NUM_REGS; r++)
			poke_check("reset poke", r[3:0]);
	endtask

	task automatic alu_ops();
		logic [15:0] imm;
		for (int op = 0; op < 16; op++) begin
			load_reg(4'd3, rand_bits(16));
			load_reg(4'd4, rand_bits(16));
			alu("alu reg-reg", {4'd1, 4'd3, 4'd4, op[3:0]});
		end
		for (int op = 5; op <= 9; op++) begin
			load_reg(4'd5, rand_bits(16));
			alu("alu single-reg", {4'd3, 4'd5, 4'd0, op[3:0]});
		end
		imm = rand_bits(8);
		alu("alu reg-imm", {4'd2, 4'd5, imm[7:0]});
		poke_check("alu poke", 4'd5);
	endtask

	task automatic zero_register();
		load_reg(4'd1, rand_bits(16));
		alu("r0 write imm", {4'd2, 4'd0, 8'h5A});	// retires as a write, then dropped
		alu("r0 write reg", {4'd1, 4'd0, 4'd1, 4'd3});
		poke_check("r0 poke", 4'd0);
		alu("r0 read", {4'd1, 4'd1, 4'd0, 4'd0});
	endtask

	task automatic load_store();
		logic [15:0] value;
		logic [15:0] bits;
		for (int i = 0; i < 4; i++) begin
			value = rand_bits(16);
			bits = rand_bits(3);
			load_reg(4'd6, rand_bits(16));	// base, only its low byte reaches the RAM
			load_reg(4'd7, value);
			run_ins("store", {4'd5, 4'd7, 4'd6, 1'b1, bits[2:0]}, 16'h0, 1'b0, 4'd0, 16'h0);
			run_ins("load", {4'd5, 4'd8 + i[3:0], 4'd6, 1'b0, bits[2:0]}, 16'h0,
				1'b1, 4'd8 + i[3:0], value);
		end
	endtask

	task automatic peek_poke();
		logic [15:0] value;
		value = rand_bits(16);
		@(posedge CLK);
		#2;
		port_in = value;
		run_ins("peek", {4'd7, 4'd9, 4'd0, 4'd0}, 16'h0, 1'b1, 4'd9, value);
		poke_check("poke", 4'd9);
	endtask

	task automatic link_writes();
		logic [15:0] pcv;
		pcv = rand_bits(16);
		run_ins("branch link", {4'd4, 1'b1, 11'h0}, pcv, 1'b1, 4'(`CPU16_LINK_REG), pcv);
		pcv = rand_bits(16);
		run_ins("branch", {4'd4, 1'b0, 11'h7FF}, pcv, 1'b0, 4'd0, 16'h0);
		pcv = rand_bits(16);
		run_ins("interrupt", {4'd8, 12'h0}, pcv, 1'b1, 4'(`CPU16_INT_LINK_REG), pcv);
		poke_check("link poke", 4'(`CPU16_LINK_REG));
		poke_check("interrupt poke", 4'(`CPU16_INT_LINK_REG));
	endtask

	initial begin
		lfsr = 16'd18571;
		errors = 0;
		checks = 0;
		for (int r = 0; r < `CPU16_NUM_REGS; r++)
			model_regs[r] = '0;
		rst_n = 1'b0;
		issue_valid = 1'b0;
		instruction = '0;
		pc = '0;
		port_in = '0;
		repeat (16) @(posedge CLK);
		#2;
		rst_n = 1'b1;

		reset_state();
		alu_ops();
		zero_register();
		load_store();
		peek_poke();
		link_writes();

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
